// ==== common/types_pkg.sv ====
// RV32I + matrix extension decode types
package types_pkg;

    // widths with meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SRL  = 4'd3,
        ALU_SRA  = 4'd4,
        ALU_AND  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // scalar opcodes
    localparam opcode_t RTYPE    = 7'b0110011;
    localparam opcode_t ITYPE    = 7'b0010011;
    localparam opcode_t ITYPE_LW = 7'b0000011;
    localparam opcode_t STYPE    = 7'b0100011;
    localparam opcode_t BTYPE    = 7'b1100011;
    localparam opcode_t JAL      = 7'b1101111;
    localparam opcode_t JALR     = 7'b1100111;
    localparam opcode_t LUI      = 7'b0110111;
    localparam opcode_t AUIPC    = 7'b0010111;
    localparam opcode_t HALT     = 7'b1111111;

    // matrix extension opcodes
    localparam opcode_t LD_M     = 7'b1000111;
    localparam opcode_t ST_M     = 7'b1010111;
    localparam opcode_t GEMM_M   = 7'b1110111;

    // r-type funct3
    localparam funct3_t ADD_SUB  = 3'h0;
    localparam funct3_t SLL      = 3'h1;
    localparam funct3_t SLT      = 3'h2;
    localparam funct3_t SLTU     = 3'h3;
    localparam funct3_t XOR      = 3'h4;
    localparam funct3_t SRL_SRA  = 3'h5;
    localparam funct3_t OR       = 3'h6;
    localparam funct3_t AND      = 3'h7;

    // i-type funct3
    localparam funct3_t ADDI      = 3'h0;
    localparam funct3_t SLLI      = 3'h1;
    localparam funct3_t SLTI      = 3'h2;
    localparam funct3_t SLTIU     = 3'h3;
    localparam funct3_t XORI      = 3'h4;
    localparam funct3_t SRLI_SRAI = 3'h5;
    localparam funct3_t ORI       = 3'h6;
    localparam funct3_t ANDI      = 3'h7;

    // only word loads and stores are supported
    localparam funct3_t LW_SW    = 3'h2;

    // branch funct3
    localparam funct3_t BEQ      = 3'h0;
    localparam funct3_t BNE      = 3'h1;
    localparam funct3_t BLT      = 3'h4;
    localparam funct3_t BGE      = 3'h5;
    localparam funct3_t BLTU     = 3'h6;
    localparam funct3_t BGEU     = 3'h7;

    localparam funct7_t SUB      = 7'h20;
    localparam funct7_t SRA      = 7'h20;

    // mem_type bits
    localparam int MEM_TO_REG = 0;
    localparam int MEM_READ   = 1;
    localparam int MEM_WRITE  = 2;

    // u_type bits
    localparam int U_LOAD = 0;
    localparam int U_ADD  = 1;

    // b_type one-hot bits
    localparam int B_BEQ  = 0;
    localparam int B_BNE  = 1;
    localparam int B_BLT  = 2;
    localparam int B_BGE  = 3;
    localparam int B_BLTU = 4;
    localparam int B_BGEU = 5;

    typedef struct packed {
        logic       hit;
        logic       reg_write;
        logic       i_flag;
        logic [2:0] mem_type;
        logic [5:0] b_type;
        logic [2:0] branch_type;
        logic       jal;
        logic       jalr;
        logic [1:0] u_type;
        alu_op_t    alu_op;
        word_t      imm;
        logic       halt;
    } scalar_ctrl_t;

    typedef struct packed {
        logic     hit;
        logic     ld_m;
        logic     st_m;
        logic     gemm;
        logic     i_flag;
        alu_op_t  alu_op;
        word_t    imm;
        reg_idx_t stride;
    } matrix_ctrl_t;

    // bundle handed to execute
    typedef struct packed {
        logic       reg_write;
        logic       i_flag;
        logic [2:0] mem_type;
        logic [5:0] b_type;
        logic [2:0] branch_type;
        logic       jal;
        logic       jalr;
        logic [1:0] u_type;
        alu_op_t    alu_op;
        word_t      imm;
        logic       halt;
        logic       ld_m;
        logic       st_m;
        logic       gemm;
        reg_idx_t   stride;
        logic       is_matrix;
        logic       illegal;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } decoded_t;

endpackage

// ==== control_unit/control_unit.sv ====
// scalar RV32I decoder
`timescale 1ns/1ns

module control_unit (
    input  types_pkg::word_t        instr,
    output types_pkg::scalar_ctrl_t ctrl
);

    import types_pkg::*;

    opcode_t op;
    funct3_t f3;
    funct7_t f7;

    assign op = instr[6:0];
    assign f3 = instr[14:12];
    assign f7 = instr[31:25];

    always_comb
    begin
        ctrl = '0;
        case (op)
            RTYPE:
            begin
                ctrl.hit       = 1'b1;
                ctrl.reg_write = 1'b1;
                case (f3)
                    ADD_SUB: ctrl.alu_op = (f7 == SUB) ? ALU_SUB : ALU_ADD;
                    SLL:     ctrl.alu_op = ALU_SLL;
                    SLT:     ctrl.alu_op = ALU_SLT;
                    SLTU:    ctrl.alu_op = ALU_SLTU;
                    XOR:     ctrl.alu_op = ALU_XOR;
                    SRL_SRA: ctrl.alu_op = (f7 == SRA) ? ALU_SRA : ALU_SRL;
                    OR:      ctrl.alu_op = ALU_OR;
                    AND:     ctrl.alu_op = ALU_AND;
                endcase
            end
            ITYPE:
            begin
                ctrl.hit       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.imm       = {{20{instr[31]}}, instr[31:20]};
                case (f3)
                    ADDI:      ctrl.alu_op = ALU_ADD;
                    SLLI:      ctrl.alu_op = ALU_SLL;
                    SLTI:      ctrl.alu_op = ALU_SLT;
                    SLTIU:     ctrl.alu_op = ALU_SLTU;
                    XORI:      ctrl.alu_op = ALU_XOR;
                    SRLI_SRAI: ctrl.alu_op = (f7 == SRA) ? ALU_SRA : ALU_SRL;
                    ORI:       ctrl.alu_op = ALU_OR;
                    ANDI:      ctrl.alu_op = ALU_AND;
                endcase
            end
            ITYPE_LW:
            begin
                if (f3 == LW_SW)
                begin
                    ctrl.hit                  = 1'b1;
                    ctrl.reg_write            = 1'b1;
                    ctrl.i_flag               = 1'b1;
                    ctrl.imm                  = {{20{instr[31]}}, instr[31:20]};
                    ctrl.mem_type[MEM_TO_REG] = 1'b1;
                    ctrl.mem_type[MEM_READ]   = 1'b1;
                end
            end
            STYPE:
            begin
                if (f3 == LW_SW)
                begin
                    ctrl.hit                 = 1'b1;
                    ctrl.i_flag              = 1'b1;
                    ctrl.imm                 = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    ctrl.mem_type[MEM_WRITE] = 1'b1;
                end
            end
            BTYPE:
            begin
                ctrl.hit = 1'b1;
                ctrl.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
                // signed compares go through subtract, unsigned through sltu
                case (f3)
                    BEQ:  begin ctrl.b_type[B_BEQ]  = 1'b1; ctrl.branch_type = 3'd1; end
                    BNE:  begin ctrl.b_type[B_BNE]  = 1'b1; ctrl.branch_type = 3'd2; end
                    BLT:  begin ctrl.b_type[B_BLT]  = 1'b1; ctrl.branch_type = 3'd3; end
                    BGE:  begin ctrl.b_type[B_BGE]  = 1'b1; ctrl.branch_type = 3'd4; end
                    BLTU: begin ctrl.b_type[B_BLTU] = 1'b1; ctrl.branch_type = 3'd5; end
                    BGEU: begin ctrl.b_type[B_BGEU] = 1'b1; ctrl.branch_type = 3'd6; end
                    default: ctrl.branch_type = 3'd0;
                endcase
                ctrl.alu_op = (f3 == BLTU || f3 == BGEU) ? ALU_SLTU : ALU_SUB;
            end
            JAL:
            begin
                ctrl.hit       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            end
            JALR:
            begin
                ctrl.hit       = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.i_flag    = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.imm       = {{20{instr[31]}}, instr[31:20]};
            end
            LUI:
            begin
                ctrl.hit            = 1'b1;
                ctrl.reg_write      = 1'b1;
                ctrl.u_type[U_LOAD] = 1'b1;
                ctrl.imm            = {instr[31:12], 12'b0};
            end
            AUIPC:
            begin
                ctrl.hit           = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.u_type[U_ADD] = 1'b1;
                ctrl.imm           = {instr[31:12], 12'b0};
            end
            HALT:
            begin
                ctrl.hit  = 1'b1;
                ctrl.halt = 1'b1;
            end
            default: ctrl.hit = 1'b0;
        endcase
    end

endmodule

// ==== control_unit/matrix_decoder.sv ====
// matrix extension decoder
`timescale 1ns/1ns

module matrix_decoder (
    input  types_pkg::word_t        instr,
    output types_pkg::matrix_ctrl_t ctrl
);

    import types_pkg::*;

    opcode_t op;

    assign op = instr[6:0];

    always_comb
    begin
        ctrl = '0;
        case (op)
            LD_M,
            ST_M:
            begin
                ctrl.hit    = 1'b1;
                ctrl.ld_m   = (op == LD_M);
                ctrl.st_m   = (op == ST_M);
                // base + imm address with the stride taken from a register
                ctrl.i_flag = 1'b1;
                ctrl.alu_op = ALU_ADD;
                ctrl.imm    = {{21{instr[17]}}, instr[17:7]};
                ctrl.stride = instr[22:18];
            end
            GEMM_M:
            begin
                // md = ma * mb + mc on operands held in the matrix unit
                ctrl.hit  = 1'b1;
                ctrl.gemm = 1'b1;
            end
            default: ctrl.hit = 1'b0;
        endcase
    end

endmodule

// ==== src/decode_stage.sv ====
// decode merge and output register
`timescale 1ns/1ns

module decode_stage (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  types_pkg::word_t        in_instr,
    input  types_pkg::scalar_ctrl_t sc,
    input  types_pkg::matrix_ctrl_t mx,
    output logic                    out_valid,
    input  logic                    out_ready,
    output types_pkg::decoded_t     out_dec,
    output logic                    halted
);

    import types_pkg::*;

    decoded_t dec_nxt;
    decoded_t dec_q;
    logic     valid_q;
    logic     halted_q;
    logic     accept;

    always_comb
    begin
        dec_nxt     = '0;
        dec_nxt.rd  = in_instr[11:7];
        dec_nxt.rs1 = in_instr[19:15];
        dec_nxt.rs2 = in_instr[24:20];
        if (mx.hit)
        begin
            dec_nxt.is_matrix = 1'b1;
            dec_nxt.ld_m      = mx.ld_m;
            dec_nxt.st_m      = mx.st_m;
            dec_nxt.gemm      = mx.gemm;
            dec_nxt.i_flag    = mx.i_flag;
            dec_nxt.alu_op    = mx.alu_op;
            dec_nxt.imm       = mx.imm;
            dec_nxt.stride    = mx.stride;
        end
        else if (sc.hit)
        begin
            dec_nxt.reg_write   = sc.reg_write;
            dec_nxt.i_flag      = sc.i_flag;
            dec_nxt.mem_type    = sc.mem_type;
            dec_nxt.b_type      = sc.b_type;
            dec_nxt.branch_type = sc.branch_type;
            dec_nxt.jal         = sc.jal;
            dec_nxt.jalr        = sc.jalr;
            dec_nxt.u_type      = sc.u_type;
            dec_nxt.alu_op      = sc.alu_op;
            dec_nxt.imm         = sc.imm;
            dec_nxt.halt        = sc.halt;
        end
        else
        begin
            dec_nxt.illegal = 1'b1;
        end
    end

    // a held halt blocks input so nothing slips in behind it
    assign in_ready = !halted_q && (!valid_q || (out_ready && !dec_q.halt));
    assign accept   = in_valid && in_ready;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q  <= 1'b0;
            halted_q <= 1'b0;
        end
        else
        begin
            if (accept)
                valid_q <= 1'b1;
            else if (out_ready)
                valid_q <= 1'b0;
            if (valid_q && out_ready && dec_q.halt)
                halted_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            dec_q <= dec_nxt;
    end

    assign out_valid = valid_q;
    assign out_dec   = dec_q;
    assign halted    = halted_q;

endmodule

// ==== src/decode_top.sv ====
// decode stage top level
`timescale 1ns/1ns

module decode_top (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  types_pkg::word_t    in_instr,
    output logic                out_valid,
    input  logic                out_ready,
    output types_pkg::decoded_t out_dec,
    output logic                halted
);

    import types_pkg::*;

    scalar_ctrl_t sc;
    matrix_ctrl_t mx;

    // both decoders see the raw word in parallel
    control_unit i_control_unit (
        .instr (in_instr),
        .ctrl  (sc)
    );

    matrix_decoder i_matrix_decoder (
        .instr (in_instr),
        .ctrl  (mx)
    );

    decode_stage i_decode_stage (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .sc        (sc),
        .mx        (mx),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec),
        .halted    (halted)
    );

endmodule

// ==== testbench/decode_tb_checks.svh ====
// testbench encoders, reference model and compare tasks

function automatic word_t sext(word_t v, int width);
    // v holds width bits with the upper bits zero
    return v[width - 1] ? (v | (32'hffff_ffff << width)) : v;
endfunction

function automatic reg_idx_t rnd_reg();
    return reg_idx_t'($urandom);
endfunction

function automatic word_t enc_r(funct7_t f7, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, RTYPE};
endfunction

function automatic word_t enc_i(logic [11:0] imm, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                opcode_t op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_b(logic [12:0] imm, funct3_t f3, reg_idx_t rs1, reg_idx_t rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BTYPE};
endfunction

function automatic word_t enc_m(opcode_t op, logic [10:0] imm, reg_idx_t stride,
                                logic [8:0] upper);
    return {upper, stride, imm, op};
endfunction

function automatic word_t rand_instr();
    opcode_t ops [13];
    word_t   w;
    // halt left out so the stream keeps flowing
    ops = '{RTYPE, ITYPE, ITYPE_LW, STYPE, BTYPE, JAL, JALR, LUI, AUIPC,
            LD_M, ST_M, GEMM_M, 7'h0b};
    w      = $urandom;
    w[6:0] = ops[$urandom % 13];
    return w;
endfunction

function automatic alu_op_t arith_op(funct3_t f3, funct7_t f7, logic imm_form);
    case (f3)
        3'd0:    return (!imm_form && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic decoded_t expect_dec(word_t w);
    decoded_t d;
    word_t    i_imm;
    d     = '0;
    i_imm = sext(w[31:20], 12);
    d.rd  = w[11:7];
    d.rs1 = w[19:15];
    d.rs2 = w[24:20];
    case (w[6:0])
        RTYPE:
        begin
            d.reg_write = 1'b1;
            d.alu_op    = arith_op(w[14:12], w[31:25], 1'b0);
        end
        ITYPE:
        begin
            d.reg_write = 1'b1;
            d.i_flag    = 1'b1;
            d.imm       = i_imm;
            d.alu_op    = arith_op(w[14:12], w[31:25], 1'b1);
        end
        ITYPE_LW:
        begin
            if (w[14:12] != 3'd2)
                d.illegal = 1'b1;
            else
            begin
                d.reg_write = 1'b1;
                d.i_flag    = 1'b1;
                d.imm       = i_imm;
                // mem_to_reg and mem_read
                d.mem_type  = 3'b011;
            end
        end
        STYPE:
        begin
            if (w[14:12] != 3'd2)
                d.illegal = 1'b1;
            else
            begin
                d.i_flag   = 1'b1;
                d.imm      = sext({w[31:25], w[11:7]}, 12);
                d.mem_type = 3'b100;
            end
        end
        BTYPE:
        begin
            d.imm    = sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
            d.alu_op = (w[14] && w[13]) ? ALU_SLTU : ALU_SUB;
            case (w[14:12])
                3'd0: d.branch_type = 3'd1;
                3'd1: d.branch_type = 3'd2;
                3'd4: d.branch_type = 3'd3;
                3'd5: d.branch_type = 3'd4;
                3'd6: d.branch_type = 3'd5;
                3'd7: d.branch_type = 3'd6;
                default: d.branch_type = 3'd0;
            endcase
            // one-hot bit sits one below the branch code
            if (d.branch_type != 3'd0)
                d.b_type[d.branch_type - 1] = 1'b1;
        end
        JAL:
        begin
            d.reg_write = 1'b1;
            d.i_flag    = 1'b1;
            d.jal       = 1'b1;
            d.imm       = sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        end
        JALR:
        begin
            d.reg_write = 1'b1;
            d.i_flag    = 1'b1;
            d.jalr      = 1'b1;
            d.imm       = i_imm;
        end
        LUI,
        AUIPC:
        begin
            d.reg_write = 1'b1;
            d.u_type    = (w[6:0] == LUI) ? 2'b01 : 2'b10;
            d.imm       = {w[31:12], 12'h000};
        end
        HALT: d.halt = 1'b1;
        LD_M,
        ST_M:
        begin
            d.is_matrix = 1'b1;
            d.ld_m      = (w[6:0] == LD_M);
            d.st_m      = (w[6:0] == ST_M);
            d.i_flag    = 1'b1;
            d.alu_op    = ALU_ADD;
            d.imm       = sext(w[17:7], 11);
            d.stride    = w[22:18];
        end
        GEMM_M:
        begin
            d.is_matrix = 1'b1;
            d.gemm      = 1'b1;
        end
        default: d.illegal = 1'b1;
    endcase
    return d;
endfunction

task automatic check_dec(decoded_t got, decoded_t exp, string what);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_alu(alu_op_t got, alu_op_t exp, string what);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAIL %0t: %s, got %s expected %s", $time, what, got.name(), exp.name());
    end
endtask

task automatic check_bit(logic got, logic exp, string what);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAIL %0t: %s, got %b expected %b", $time, what, got, exp);
    end
endtask

// ==== testbench/decode_tb.sv ====
// decode stage testbench
`timescale 1ns/1ns

module decode_tb;

    import types_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int N_ALU      = 19;
    localparam int N_MEM      = 26;
    localparam int N_BR       = 12;
    localparam int N_MX       = 12;
    localparam int N_STREAM   = 40;
    localparam int N_BURST    = 8;
    localparam int N_HALT     = 3;
    localparam int N_ISSUED   = N_ALU + N_MEM + N_BR + N_MX + N_STREAM + N_BURST + N_HALT;
    localparam int WATCHDOG_CYCLES = N_ISSUED * 40 + 200;

    logic     CLK;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    word_t    in_instr;
    logic     out_valid;
    logic     out_ready;
    decoded_t out_dec;
    logic     halted;
    int       errors;
    int       checks;

    decode_top i_dut (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec),
        .halted    (halted)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    `include "decode_tb_checks.svh"

    // hold the word on the input until the stage takes it
    task automatic issue(word_t w);
        int waited;
        waited = 0;
        @(posedge CLK);
        in_valid <= 1'b1;
        in_instr <= w;
        @(negedge CLK);
        while (!in_ready && waited < 20)
        begin
            @(negedge CLK);
            waited++;
        end
        if (!in_ready)
        begin
            errors++;
            $display("handshake timeout at %0t: instruction %h was never accepted", $time, w);
        end
        @(posedge CLK);
        in_valid <= 1'b0;
    endtask

    task automatic decode_and_check(input word_t w, output decoded_t got);
        issue(w);
        @(negedge CLK);
        check_bit(out_valid, 1'b1, "out_valid one cycle after accept");
        got = out_dec;
        check_dec(got, expect_dec(w), $sformatf("decode of %h", w));
    endtask

    task automatic alu_test();
        alu_op_t     base [8];
        alu_op_t     exp;
        decoded_t    got;
        funct7_t     f7;
        logic [11:0] imm;
        int          f3;
        int          alt;
        base = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
        for (f3 = 0; f3 < 8; f3++)
        begin
            for (alt = 0; alt < 2; alt++)
            begin
                if (alt == 0 || f3 == 0 || f3 == 5)
                begin
                    f7  = alt ? 7'h20 : 7'h00;
                    exp = alt ? ((f3 == 0) ? ALU_SUB : ALU_SRA) : base[f3];
                    decode_and_check(enc_r(f7, funct3_t'(f3), rnd_reg(), rnd_reg(), rnd_reg()),
                                     got);
                    check_alu(got.alu_op, exp, "r-type alu_op");
                    // there is no subtract immediate
                    if (f3 != 0 || alt == 0)
                    begin
                        imm = (f3 == 1 || f3 == 5) ? {f7, 5'($urandom)} : 12'($urandom);
                        decode_and_check(enc_i(imm, funct3_t'(f3), rnd_reg(), rnd_reg(), ITYPE),
                                         got);
                        check_alu(got.alu_op, exp, "i-type alu_op");
                    end
                end
            end
        end
    endtask

    task automatic mem_jump_test();
        opcode_t  ops [6];
        decoded_t got;
        word_t    w;
        int       k;
        int       i;
        ops = '{ITYPE_LW, STYPE, JAL, JALR, LUI, AUIPC};
        for (k = 0; k < 6; k++)
        begin
            for (i = 0; i < 4; i++)
            begin
                w      = $urandom;
                w[6:0] = ops[k];
                if (k < 2)
                    w[14:12] = LW_SW;
                decode_and_check(w, got);
            end
        end
        // byte and halfword accesses
        decode_and_check(enc_i(12'($urandom), 3'd0, rnd_reg(), rnd_reg(), ITYPE_LW), got);
        check_bit(got.illegal, 1'b1, "lb is illegal");
        w        = $urandom;
        w[6:0]   = STYPE;
        w[14:12] = 3'd1;
        decode_and_check(w, got);
        check_bit(got.illegal, 1'b1, "sh is illegal");
    endtask

    task automatic branch_test();
        funct3_t     f3s [6];
        decoded_t    got;
        logic [12:0] imm;
        int          k;
        int          i;
        f3s = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        for (k = 0; k < 6; k++)
        begin
            for (i = 0; i < 2; i++)
            begin
                imm = {12'($urandom), 1'b0};
                decode_and_check(enc_b(imm, f3s[k], rnd_reg(), rnd_reg()), got);
                check_bit(got.b_type[k], 1'b1, "one-hot branch bit");
                check_alu(got.alu_op, (k >= 4) ? ALU_SLTU : ALU_SUB, "branch alu_op");
                check_bit(got.imm[0], 1'b0, "branch imm bit 0");
            end
        end
    endtask

    task automatic matrix_test();
        decoded_t got;
        opcode_t  op;
        word_t    w;
        int       i;
        for (i = 0; i < 8; i++)
        begin
            op = i[0] ? ST_M : LD_M;
            decode_and_check(enc_m(op, 11'($urandom), rnd_reg(), 9'($urandom)), got);
            check_bit(got.is_matrix, 1'b1, "is_matrix on ld.m/st.m");
            check_bit(i[0] ? got.st_m : got.ld_m, 1'b1, "ld.m/st.m flag");
        end
        for (i = 0; i < 4; i++)
        begin
            w      = $urandom;
            w[6:0] = (i < 2) ? GEMM_M : ((i == 2) ? 7'h0b : 7'h5b);
            decode_and_check(w, got);
            check_bit((i < 2) ? got.gemm : got.illegal, 1'b1, "gemm or illegal flag");
        end
    endtask

    task automatic stream_test();
        decoded_t expq [$];
        decoded_t held;
        word_t    burst [N_BURST];
        word_t    w;
        logic     stalled;
        int       got_n;
        int       i;
        got_n   = 0;
        stalled = 1'b0;
        fork
            begin
                for (i = 0; i < N_STREAM; i++)
                begin
                    w = rand_instr();
                    expq.push_back(expect_dec(w));
                    issue(w);
                end
            end
            begin
                while (got_n < N_STREAM)
                begin
                    @(posedge CLK);
                    out_ready <= 1'($urandom);
                end
            end
            begin
                while (got_n < N_STREAM)
                begin
                    @(negedge CLK);
                    if (stalled)
                        check_dec(out_dec, held, "out_dec held while stalled");
                    stalled = out_valid && !out_ready;
                    held    = out_dec;
                    if (stalled)
                        check_bit(in_ready, 1'b0, "in_ready low while stalled");
                    if (out_valid && out_ready)
                    begin
                        check_dec(out_dec, expq.pop_front(), "stream bundle in order");
                        got_n++;
                    end
                end
            end
        join
        @(posedge CLK);
        out_ready <= 1'b1;
        // back to back at full rate
        for (i = 0; i < N_BURST; i++)
        begin
            burst[i] = rand_instr();
            @(posedge CLK);
            in_valid <= 1'b1;
            in_instr <= burst[i];
            @(negedge CLK);
            check_bit(in_ready, 1'b1, "in_ready in full-rate burst");
            if (i > 0)
            begin
                check_bit(out_valid, 1'b1, "out_valid in full-rate burst");
                check_dec(out_dec, expect_dec(burst[i - 1]), "burst bundle one cycle later");
            end
        end
        @(posedge CLK);
        in_valid <= 1'b0;
        @(negedge CLK);
        check_bit(out_valid, 1'b1, "out_valid on last burst bundle");
        check_dec(out_dec, expect_dec(burst[N_BURST - 1]), "last burst bundle");
    endtask

    task automatic halt_test();
        decoded_t got;
        word_t    addi;
        int       i;
        addi = enc_i(12'($urandom), ADDI, rnd_reg(), rnd_reg(), ITYPE);
        decode_and_check({25'($urandom), HALT}, got);
        check_bit(got.halt, 1'b1, "halt bundle");
        check_bit(in_ready, 1'b0, "in_ready low behind held halt");
        check_bit(halted, 1'b0, "halted before halt is taken");
        @(posedge CLK);
        in_valid <= 1'b1;
        in_instr <= addi;
        for (i = 0; i < 5; i++)
        begin
            @(negedge CLK);
            check_bit(halted, 1'b1, "halted after halt is taken");
            check_bit(in_ready, 1'b0, "in_ready low while halted");
            check_bit(out_valid, 1'b0, "no bundle after halt");
        end
        @(posedge CLK);
        in_valid <= 1'b0;
        rst_n    <= 1'b0;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        check_bit(halted, 1'b0, "halted cleared by reset");
        check_bit(in_ready, 1'b1, "in_ready after second reset");
        decode_and_check(addi, got);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        void'($urandom(94));
        CLK       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b1;
        errors    = 0;
        checks    = 0;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_bit(out_valid, 1'b0, "out_valid after reset");
        alu_test();
        mem_jump_test();
        branch_test();
        matrix_test();
        stream_test();
        halt_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== rv_matrix_decode.f ====
+incdir+testbench
common/types_pkg.sv
control_unit/control_unit.sv
control_unit/matrix_decoder.sv
src/decode_stage.sv
src/decode_top.sv
testbench/decode_tb.sv

// ==== Bender.yml ====
package:
  name: rv_matrix_decode

sources:
  - common/types_pkg.sv
  - control_unit/control_unit.sv
  - control_unit/matrix_decoder.sv
  - src/decode_stage.sv
  - src/decode_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/decode_tb.sv
